// File: design/krypton_pkg.sv
// Shared widths, dispatch and register enums, stream and APB structs, register bit positions
`default_nettype none

package krypton_pkg;

    // ====================
    // Widths
    // ====================

    // Shader program counter
    localparam int ADDR_WIDTH = 40;

    // Thread count and dispatch counters
    localparam int COUNT_WIDTH = 32;

    // Free-running cycle counter
    localparam int CYCLE_WIDTH = 64;

    localparam int APB_ADDR_WIDTH = 12;
    localparam int APB_DATA_WIDTH = 32;

    // ====================
    // Enums
    // ====================

    typedef enum logic {
        KIND_VERTEX = 1'b0,
        KIND_PIXEL  = 1'b1
    } dispatch_kind_e;

    // Word addresses, APB byte address without its two low bits
    typedef enum logic [APB_ADDR_WIDTH-3:0] {
        REG_CTRL      = 10'h000,
        REG_STATUS    = 10'h001,
        REG_FENCE_ACK = 10'h002,
        REG_CYCLES_LO = 10'h020,
        REG_CYCLES_HI = 10'h021,
        REG_VERTICES  = 10'h022,
        REG_PIXELS    = 10'h023
    } reg_word_e;

    // Bit positions inside the control registers
    localparam int CTRL_ENABLE_BIT  = 0;
    localparam int STATUS_BUSY_BIT  = 0;
    localparam int STATUS_FENCE_BIT = 1;
    localparam int FENCE_ACK_BIT    = 0;

    // ====================
    // Structs
    // ====================

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]  shader_pc;
        logic [COUNT_WIDTH-1:0] thread_count;
    } shader_work_t;

    typedef struct packed {
        dispatch_kind_e kind;
        shader_work_t   work;
    } cluster_dispatch_t;

    typedef struct packed {
        logic                      sel;
        logic                      enable;
        logic                      write;
        logic [APB_ADDR_WIDTH-1:0] addr;
        logic [APB_DATA_WIDTH-1:0] wdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_WIDTH-1:0] prdata;
        logic                      pready;
        logic                      pslverr;
    } apb_resp_t;

    typedef struct packed {
        logic [CYCLE_WIDTH-1:0] cycles;
        logic [COUNT_WIDTH-1:0] vertices;
        logic [COUNT_WIDTH-1:0] pixels;
    } perf_counts_t;

endpackage

`default_nettype wire

// File: design/krypton_apb_regs.sv
// APB register block with dispatch enable, status, fence interrupt and counter read-back
`timescale 1ns/1ps
`default_nettype none

module krypton_apb_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  krypton_pkg::apb_req_t     apb_req,
    output krypton_pkg::apb_resp_t    apb_resp,
    input  logic                      busy,
    input  logic                      fence_event,
    input  krypton_pkg::perf_counts_t perf,
    output logic                      dispatch_enable,
    output logic                      irq_fence
);

    // ====================
    // Decode
    // ====================

    krypton_pkg::reg_word_e                   word_addr;
    logic                                     access;
    logic                                     wr_access;
    logic                                     mapped;
    logic [krypton_pkg::APB_DATA_WIDTH-1:0]   rd_data;
    logic                                     ack_write;

    logic                                     pready_q;
    logic                                     pslverr_q;
    logic [krypton_pkg::APB_DATA_WIDTH-1:0]   prdata_q;

    assign word_addr = krypton_pkg::reg_word_e'(
        apb_req.addr[krypton_pkg::APB_ADDR_WIDTH-1:2]);

    // One access per transfer, the held access phase is ignored while pready is up
    assign access    = apb_req.sel && apb_req.enable && !pready_q;
    assign wr_access = access && apb_req.write;

    assign ack_write = wr_access && (word_addr == krypton_pkg::REG_FENCE_ACK)
                       && apb_req.wdata[krypton_pkg::FENCE_ACK_BIT];

    // Read mux and address map check
    always_comb begin
        mapped  = 1'b1;
        rd_data = '0;
        case (word_addr)
            krypton_pkg::REG_CTRL: begin
                rd_data[krypton_pkg::CTRL_ENABLE_BIT] = dispatch_enable;
            end
            krypton_pkg::REG_STATUS: begin
                rd_data[krypton_pkg::STATUS_BUSY_BIT]  = busy;
                rd_data[krypton_pkg::STATUS_FENCE_BIT] = irq_fence;
            end
            krypton_pkg::REG_FENCE_ACK: begin
                rd_data = '0;
            end
            krypton_pkg::REG_CYCLES_LO: begin
                rd_data = perf.cycles[krypton_pkg::APB_DATA_WIDTH-1:0];
            end
            krypton_pkg::REG_CYCLES_HI: begin
                rd_data = perf.cycles[krypton_pkg::CYCLE_WIDTH-1:krypton_pkg::APB_DATA_WIDTH];
            end
            krypton_pkg::REG_VERTICES: begin
                rd_data = perf.vertices;
            end
            krypton_pkg::REG_PIXELS: begin
                rd_data = perf.pixels;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    // ====================
    // Registers
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pready_q        <= 1'b0;
            pslverr_q       <= 1'b0;
            dispatch_enable <= 1'b0;
            irq_fence       <= 1'b0;
        end else begin
            pready_q  <= access;
            pslverr_q <= access && !mapped;

            if (wr_access && (word_addr == krypton_pkg::REG_CTRL)) begin
                dispatch_enable <= apb_req.wdata[krypton_pkg::CTRL_ENABLE_BIT];
            end

            // A new fence event wins over an ack in the same cycle
            if (fence_event) begin
                irq_fence <= 1'b1;
            end else if (ack_write) begin
                irq_fence <= 1'b0;
            end
        end
    end

    // Writes and unmapped reads return zero
    always_ff @(posedge clk) begin
        if (access) begin
            prdata_q <= apb_req.write ? '0 : rd_data;
        end
    end

    assign apb_resp = '{
        prdata:  prdata_q,
        pready:  pready_q,
        pslverr: pslverr_q
    };

endmodule

`default_nettype wire

// File: design/krypton_work_dispatcher.sv
// Round-robin distributor of vertex and pixel work into per-cluster holding slots
`timescale 1ns/1ps
`default_nettype none

module krypton_work_dispatcher #(
    parameter int NUM_CLUSTERS = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           dispatch_enable,
    input  logic                           vs_valid,
    input  krypton_pkg::shader_work_t      vs_work,
    output logic                           vs_ready,
    input  logic                           ps_valid,
    input  krypton_pkg::shader_work_t      ps_work,
    output logic                           ps_ready,
    output logic [NUM_CLUSTERS-1:0]        cluster_valid,
    output krypton_pkg::cluster_dispatch_t cluster_dispatch [NUM_CLUSTERS],
    input  logic [NUM_CLUSTERS-1:0]        cluster_ready,
    output logic                           vs_fire,
    output logic                           ps_fire,
    output logic                           busy
);

    localparam int PTR_WIDTH = $clog2(NUM_CLUSTERS);
    localparam logic [PTR_WIDTH-1:0] LAST_PTR = PTR_WIDTH'(NUM_CLUSTERS - 1);

    logic [PTR_WIDTH-1:0]           rr_ptr;
    logic [NUM_CLUSTERS-1:0]        slot_drain;
    logic                           slot_open;
    logic                           accept;
    krypton_pkg::cluster_dispatch_t accept_item;

    // ====================
    // Arbitration
    // ====================

    assign slot_drain = cluster_valid & cluster_ready;

    // Slot at the pointer is empty or empties this cycle
    assign slot_open = !cluster_valid[rr_ptr] || cluster_ready[rr_ptr];

    // Pixel work only moves when no vertex work is offered
    assign vs_ready = dispatch_enable && slot_open;
    assign ps_ready = dispatch_enable && slot_open && !vs_valid;

    assign vs_fire = vs_valid && vs_ready;
    assign ps_fire = ps_valid && ps_ready;
    assign accept  = vs_fire || ps_fire;

    // Tag the winner with its kind
    always_comb begin
        if (vs_fire) begin
            accept_item.kind = krypton_pkg::KIND_VERTEX;
            accept_item.work = vs_work;
        end else begin
            accept_item.kind = krypton_pkg::KIND_PIXEL;
            accept_item.work = ps_work;
        end
    end

    // ====================
    // Slots and pointer
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr        <= '0;
            cluster_valid <= '0;
        end else begin
            for (int i = 0; i < NUM_CLUSTERS; i++) begin
                if (accept && (rr_ptr == PTR_WIDTH'(i))) begin
                    cluster_valid[i] <= 1'b1;
                end else if (slot_drain[i]) begin
                    cluster_valid[i] <= 1'b0;
                end
            end

            // Wrap explicitly, NUM_CLUSTERS need not be a power of two
            if (accept) begin
                rr_ptr <= (rr_ptr == LAST_PTR) ? '0 : rr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cluster_dispatch[rr_ptr] <= accept_item;
        end
    end

    // Work waiting at the inputs or held in any slot
    assign busy = (|cluster_valid) || vs_valid || ps_valid;

endmodule

`default_nettype wire

// File: design/krypton_perf_counters.sv
// Free-running cycle counter and wrapping vertex and pixel dispatch counters
`timescale 1ns/1ps
`default_nettype none

module krypton_perf_counters (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      vs_fire,
    input  logic                      ps_fire,
    output krypton_pkg::perf_counts_t perf
);

    // ====================
    // Counters
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            perf <= '0;
        end else begin
            // Counts every cycle since reset release
            perf.cycles <= perf.cycles + krypton_pkg::CYCLE_WIDTH'(1);

            // Dispatch counts, wrap on overflow
            if (vs_fire) begin
                perf.vertices <= perf.vertices + krypton_pkg::COUNT_WIDTH'(1);
            end
            if (ps_fire) begin
                perf.pixels <= perf.pixels + krypton_pkg::COUNT_WIDTH'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: design/krypton_gpu_ctrl_top.sv
// Control front end top level with APB registers, work dispatcher and performance counters
`timescale 1ns/1ps
`default_nettype none

module krypton_gpu_ctrl_top #(
    parameter int NUM_CLUSTERS = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,

    // APB slave
    input  krypton_pkg::apb_req_t          apb_req,
    output krypton_pkg::apb_resp_t         apb_resp,

    // Vertex work stream
    input  logic                           vs_valid,
    input  krypton_pkg::shader_work_t      vs_work,
    output logic                           vs_ready,

    // Pixel work stream
    input  logic                           ps_valid,
    input  krypton_pkg::shader_work_t      ps_work,
    output logic                           ps_ready,

    // Shader cluster streams
    output logic [NUM_CLUSTERS-1:0]        cluster_valid,
    output krypton_pkg::cluster_dispatch_t cluster_dispatch [NUM_CLUSTERS],
    input  logic [NUM_CLUSTERS-1:0]        cluster_ready,

    // Fence and status
    input  logic                           fence_event,
    output logic                           irq_fence,
    output logic                           gpu_busy
);

    // ====================
    // Internal wires
    // ====================

    logic                      dispatch_enable;
    logic                      vs_fire;
    logic                      ps_fire;
    krypton_pkg::perf_counts_t perf;

    // ====================
    // Instances
    // ====================

    krypton_apb_regs krypton_apb_regs_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .apb_req         (apb_req),
        .apb_resp        (apb_resp),
        .busy            (gpu_busy),
        .fence_event     (fence_event),
        .perf            (perf),
        .dispatch_enable (dispatch_enable),
        .irq_fence       (irq_fence)
    );

    krypton_work_dispatcher #(
        .NUM_CLUSTERS (NUM_CLUSTERS)
    ) krypton_work_dispatcher_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .dispatch_enable  (dispatch_enable),
        .vs_valid         (vs_valid),
        .vs_work          (vs_work),
        .vs_ready         (vs_ready),
        .ps_valid         (ps_valid),
        .ps_work          (ps_work),
        .ps_ready         (ps_ready),
        .cluster_valid    (cluster_valid),
        .cluster_dispatch (cluster_dispatch),
        .cluster_ready    (cluster_ready),
        .vs_fire          (vs_fire),
        .ps_fire          (ps_fire),
        .busy             (gpu_busy)
    );

    krypton_perf_counters krypton_perf_counters_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .vs_fire (vs_fire),
        .ps_fire (ps_fire),
        .perf    (perf)
    );

endmodule

`default_nettype wire

// File: include/krypton_tb_ref.svh
// Reference functions, compare tasks, APB driver tasks and random work source for the testbench
`ifndef KRYPTON_TB_REF_SVH
`define KRYPTON_TB_REF_SVH

// ====================
// Reference model
// ====================

// Item k lands at cluster k mod N under strict round-robin
function automatic int expected_cluster(input int accept_index);
    return accept_index % NUM_CLUSTERS;
endfunction

function automatic krypton_pkg::dispatch_kind_e expected_kind(input logic from_vertex);
    return from_vertex ? krypton_pkg::KIND_VERTEX : krypton_pkg::KIND_PIXEL;
endfunction

// Dispatch enable sits in bit 0
function automatic logic [31:0] expected_ctrl(input logic enable);
    logic [31:0] word;
    word = '0;
    word[0] = enable;
    return word;
endfunction

// Busy in bit 0 and fence pending in bit 1
function automatic logic [31:0] expected_status(input logic busy, input logic fence);
    logic [31:0] word;
    word = '0;
    word[0] = busy;
    word[1] = fence;
    return word;
endfunction

// Work offered at the inputs or still held in a cluster slot
function automatic logic expected_busy();
    int held = 0;
    for (int i = 0; i < NUM_CLUSTERS; i++) begin
        held += expect_q[i].size();
    end
    return (held > 0) || vs_valid || ps_valid;
endfunction

function automatic logic [krypton_pkg::APB_ADDR_WIDTH-1:0] reg_addr(
    input krypton_pkg::reg_word_e word);
    return {word, 2'b00};
endfunction

function automatic krypton_pkg::shader_work_t random_work();
    krypton_pkg::shader_work_t work;
    logic [63:0]               pc_bits;
    pc_bits           = {$random(seed), $random(seed)};
    work.shader_pc    = pc_bits[krypton_pkg::ADDR_WIDTH-1:0];
    work.thread_count = $random(seed);
    return work;
endfunction

// ====================
// Compare tasks
// ====================

task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
endtask

task automatic check_dispatch(input string name, input krypton_pkg::cluster_dispatch_t expected,
                              input krypton_pkg::cluster_dispatch_t actual);
    if (actual !== expected) begin
        stop_with_error($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h",
                                  name, expected, actual));
    end
endtask

task automatic check_word(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (actual !== expected) begin
        stop_with_error($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h",
                                  name, expected, actual));
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        stop_with_error($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h",
                                  name, expected, actual));
    end
endtask

// ====================
// APB driver
// ====================

// Setup, access, then wait for pready
task automatic apb_transfer(input logic write, input logic [krypton_pkg::APB_ADDR_WIDTH-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge clk);
    #1;
    apb_req = '{sel: 1'b1, enable: 1'b0, write: write, addr: addr, wdata: wdata};
    @(posedge clk);
    #1;
    apb_req.enable = 1'b1;
    @(negedge clk);
    while (!apb_resp.pready) begin
        @(negedge clk);
    end
    rdata = apb_resp.prdata;
    err   = apb_resp.pslverr;
    @(posedge clk);
    #1;
    apb_req = '0;
endtask

// No expected item may be left once all streams are idle
task automatic wait_drained();
    do begin
        @(negedge clk);
    end while ((vs_loaded != vs_target) || (ps_loaded != ps_target) || vs_valid
               || ps_valid || (cluster_valid != '0));
    for (int i = 0; i < NUM_CLUSTERS; i++) begin
        if (expect_q[i].size() != 0) begin
            stop_with_error($sformatf("Cluster %0d never delivered %0d accepted item(s)",
                                      i, expect_q[i].size()));
        end
    end
endtask

`endif

// File: test/krypton_tb.sv
// Testbench top with clock, reset, stream driver, handshake monitor, watchdog and test sequence
`timescale 1ns/1ps
`default_nettype none

module krypton_tb;

    localparam int NUM_CLUSTERS    = 4;
    localparam int PHASE_ITEMS     = 24;
    // Two held items plus two phases on both streams
    localparam int NUM_ITEMS       = 2 + 4 * PHASE_ITEMS;
    localparam int WATCHDOG_CYCLES = NUM_ITEMS * 20 + 400;

    logic                           clk = 1'b0;
    logic                           rst_n;
    krypton_pkg::apb_req_t          apb_req;
    krypton_pkg::apb_resp_t         apb_resp;
    logic                           vs_valid;
    krypton_pkg::shader_work_t      vs_work;
    logic                           vs_ready;
    logic                           ps_valid;
    krypton_pkg::shader_work_t      ps_work;
    logic                           ps_ready;
    logic [NUM_CLUSTERS-1:0]        cluster_valid;
    krypton_pkg::cluster_dispatch_t cluster_dispatch [NUM_CLUSTERS];
    logic [NUM_CLUSTERS-1:0]        cluster_ready;
    logic                           fence_event;
    logic                           irq_fence;
    logic                           gpu_busy;

    integer                         seed = 32'h0a870ae8;
    int                             vs_target = 0;
    int                             ps_target = 0;
    int                             vs_loaded = 0;
    int                             ps_loaded = 0;
    logic                           vs_taken = 1'b0;
    logic                           ps_taken = 1'b0;
    logic                           random_ready = 1'b0;
    int                             accept_index = 0;
    int                             vs_count = 0;
    int                             ps_count = 0;
    krypton_pkg::cluster_dispatch_t expect_q [NUM_CLUSTERS][$];
    logic [31:0]                    rd_data;
    logic [31:0]                    first_cycles;
    logic                           rd_err;

    `include "krypton_tb_ref.svh"

    krypton_gpu_ctrl_top #(
        .NUM_CLUSTERS (NUM_CLUSTERS)
    ) krypton_gpu_ctrl_top_inst (.*);

    always #50 clk = ~clk;

    // ====================
    // Stream driver
    // ====================

    initial begin
        vs_valid      = 1'b0;
        vs_work       = '0;
        ps_valid      = 1'b0;
        ps_work       = '0;
        cluster_ready = '0;
        forever begin
            @(posedge clk);
            #1;
            if (vs_valid && vs_taken) begin
                vs_valid = 1'b0;
            end
            if (ps_valid && ps_taken) begin
                ps_valid = 1'b0;
            end
            // New items appear at random and stay until taken
            if (!vs_valid && (vs_loaded < vs_target) && ($random(seed) & 1)) begin
                vs_work = random_work();
                vs_valid = 1'b1;
                vs_loaded++;
            end
            if (!ps_valid && (ps_loaded < ps_target) && ($random(seed) & 1)) begin
                ps_work = random_work();
                ps_valid = 1'b1;
                ps_loaded++;
            end
            cluster_ready = random_ready ? NUM_CLUSTERS'($random(seed)) : '1;
        end
    end

    // ====================
    // Monitor and compare
    // ====================

    always @(negedge clk) begin
        krypton_pkg::cluster_dispatch_t item;
        vs_taken = vs_valid && vs_ready;
        ps_taken = ps_valid && ps_ready;
        if (vs_valid && ps_valid) begin
            check_bit("ps_ready", 1'b0, ps_ready);
        end
        if (vs_taken || ps_taken) begin
            item.kind = expected_kind(vs_taken);
            item.work = vs_taken ? vs_work : ps_work;
            expect_q[expected_cluster(accept_index)].push_back(item);
            accept_index++;
        end
        if (vs_taken) begin
            vs_count++;
        end
        if (ps_taken) begin
            ps_count++;
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            check_bit("gpu_busy", expected_busy(), gpu_busy);
            for (int i = 0; i < NUM_CLUSTERS; i++) begin
                if (cluster_valid[i] && (expect_q[i].size() == 0)) begin
                    stop_with_error($sformatf("Cluster %0d shows an item that was never sent", i));
                end
                if (cluster_valid[i] && cluster_ready[i]) begin
                    check_dispatch($sformatf("cluster_dispatch[%0d]", i),
                                   expect_q[i].pop_front(), cluster_dispatch[i]);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_error($sformatf("Watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    // ====================
    // Test sequence
    // ====================

    initial begin
        apb_req     = '0;
        fence_event = 1'b0;
        rst_n       = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Offered work must wait while dispatch is disabled
        vs_target = 1;
        ps_target = 1;
        repeat (6) begin
            @(negedge clk);
            check_bit("vs_ready", 1'b0, vs_ready);
            check_bit("ps_ready", 1'b0, ps_ready);
        end
        while (!(vs_valid && ps_valid)) begin
            @(negedge clk);
        end
        apb_transfer(1'b0, reg_addr(krypton_pkg::REG_STATUS), '0, rd_data, rd_err);
        check_word("REG_STATUS", expected_status(1'b1, 1'b0), rd_data);
        apb_transfer(1'b0, reg_addr(krypton_pkg::REG_CTRL), '0, rd_data, rd_err);
        check_word("REG_CTRL", expected_ctrl(1'b0), rd_data);
        apb_transfer(1'b1, reg_addr(krypton_pkg::REG_CTRL), 32'h1, rd_data, rd_err);
        check_bit("pslverr", 1'b0, rd_err);

        // Always-ready clusters first and random back-pressure after
        vs_target += PHASE_ITEMS;
        ps_target += PHASE_ITEMS;
        wait_drained();
        random_ready = 1'b1;
        vs_target += PHASE_ITEMS;
        ps_target += PHASE_ITEMS;
        wait_drained();

        apb_transfer(1'b0, reg_addr(krypton_pkg::REG_VERTICES), '0, rd_data, rd_err);
        check_word("REG_VERTICES", vs_count, rd_data);
        apb_transfer(1'b0, reg_addr(krypton_pkg::REG_PIXELS), '0, rd_data, rd_err);
        check_word("REG_PIXELS", ps_count, rd_data);
        apb_transfer(1'b0, reg_addr(krypton_pkg::REG_CYCLES_LO), '0, first_cycles, rd_err);
        apb_transfer(1'b0, reg_addr(krypton_pkg::REG_CYCLES_LO), '0, rd_data, rd_err);
        check_bit("REG_CYCLES_LO increasing", 1'b1, rd_data > first_cycles);
        apb_transfer(1'b0, reg_addr(krypton_pkg::REG_CYCLES_HI), '0, rd_data, rd_err);
        check_word("REG_CYCLES_HI", 32'h0, rd_data);
        apb_transfer(1'b0, 12'h100, '0, rd_data, rd_err);
        check_word("unmapped prdata", 32'h0, rd_data);
        check_bit("pslverr", 1'b1, rd_err);

        // Fence raise and acknowledge
        @(posedge clk);
        #1;
        fence_event = 1'b1;
        @(posedge clk);
        #1;
        fence_event = 1'b0;
        @(negedge clk);
        check_bit("irq_fence", 1'b1, irq_fence);
        apb_transfer(1'b0, reg_addr(krypton_pkg::REG_STATUS), '0, rd_data, rd_err);
        check_word("REG_STATUS", expected_status(1'b0, 1'b1), rd_data);
        apb_transfer(1'b1, reg_addr(krypton_pkg::REG_FENCE_ACK), 32'h1, rd_data, rd_err);
        @(negedge clk);
        check_bit("irq_fence", 1'b0, irq_fence);
        apb_transfer(1'b0, reg_addr(krypton_pkg::REG_STATUS), '0, rd_data, rd_err);
        check_word("REG_STATUS", expected_status(1'b0, 1'b0), rd_data);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
design/krypton_pkg.sv
design/krypton_apb_regs.sv
design/krypton_work_dispatcher.sv
design/krypton_perf_counters.sv
design/krypton_gpu_ctrl_top.sv
test/krypton_tb.sv
